// ==== src/uart_pkg.sv ====
package uart_pkg;

  typedef logic [7:0] byte_t;

  // 0..7 select 4800, 9600, 14400, 19200, 38400, 57600, 115200, 230400 baud.
  typedef logic [2:0] baud_sel_t;

  typedef struct packed {
    baud_sel_t baud_sel;
    logic      parity_en;
  } lcr_t;

  typedef struct packed {
    byte_t data;
    logic  parity_error;
    logic  framing_error;
    logic  overrun;
  } rx_word_t;

  localparam int frame_bits = 11;  // Start, 8 data, parity, stop.
  localparam int oversample = 16;  // Receiver ticks per bit.

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_SHIFT
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP,
    RX_WAIT
  } rx_state_e;

endpackage

// ==== src/baud_generator.sv ====
`timescale 1ns/1ps

module baud_generator import uart_pkg::*; #(
  parameter int clk_freq    = 3686400,
  parameter int sampling    = 16,
  parameter int frame_ticks = 176
) (
  input  logic      clk,
  input  logic      reset_n,
  input  baud_sel_t baud_sel,
  input  logic      start,
  output logic      tick,
  output logic      ready,
  output logic      finish
);

  localparam int rem_w = $clog2(frame_ticks + 1);

  typedef enum logic [1:0] {
    IDLE,
    PS,
    GENERATOR,
    FIN
  } state_e;

  state_e           state;
  state_e           next_state;
  logic [15:0]      divisor;
  logic [15:0]      count;
  logic [rem_w-1:0] remaining;
  logic             period_end;
  logic             last_period;

  // Rate table.
  always_ff @(posedge clk) begin
    case (baud_sel)
      3'd0:    divisor <= 16'(clk_freq / (sampling * 4800));
      3'd1:    divisor <= 16'(clk_freq / (sampling * 9600));
      3'd2:    divisor <= 16'(clk_freq / (sampling * 14400));
      3'd3:    divisor <= 16'(clk_freq / (sampling * 19200));
      3'd4:    divisor <= 16'(clk_freq / (sampling * 38400));
      3'd5:    divisor <= 16'(clk_freq / (sampling * 57600));
      3'd6:    divisor <= 16'(clk_freq / (sampling * 115200));
      default: divisor <= 16'(clk_freq / (sampling * 230400));
    endcase
  end

  assign period_end  = (state == GENERATOR) && (count == divisor - 16'd1);
  assign last_period = (remaining == rem_w'(1));

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (start) next_state = PS;
      PS:        next_state = GENERATOR;
      GENERATOR: if (period_end && last_period) next_state = FIN;
      FIN:       next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state     <= IDLE;
      count     <= '0;
      remaining <= '0;
      tick      <= 1'b0;
      ready     <= 1'b0;
      finish    <= 1'b0;
    end else begin
      state  <= next_state;
      ready  <= (state == PS);
      tick   <= period_end && !last_period;
      finish <= period_end && last_period;  // Last period ends without a tick.
      if (state == PS) begin
        remaining <= rem_w'(frame_ticks);
        count     <= '0;
      end else if (period_end) begin
        remaining <= remaining - 1'b1;
        count     <= '0;
      end else if (state == GENERATOR) begin
        count <= count + 16'd1;
      end
    end
  end

  // The client must wait for finish before the next frame.
  start_only_when_idle: assert property (
    @(posedge clk) disable iff (!reset_n) start |-> state == IDLE
  );

endmodule

// ==== src/host_write_port.sv ====
`timescale 1ns/1ps

module host_write_port import uart_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  tx_req,
  input  byte_t tx_data,
  output logic  tx_ack,
  output logic  hold_valid,
  output byte_t hold_data,
  input  logic  tx_take
);

  typedef enum logic {
    WP_IDLE,
    WP_ACK
  } wp_state_e;

  wp_state_e state;
  logic      load;

  // Only accept while the holding register is empty.
  assign load = (state == WP_IDLE) && tx_req && !hold_valid;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= WP_IDLE;
      tx_ack     <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      if (tx_take) hold_valid <= 1'b0;
      case (state)
        WP_IDLE: begin
          if (load) begin
            hold_valid <= 1'b1;
            tx_ack     <= 1'b1;
            state      <= WP_ACK;
          end
        end
        WP_ACK: begin
          if (!tx_req) begin
            tx_ack <= 1'b0;
            state  <= WP_IDLE;
          end
        end
        default: state <= WP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) hold_data <= tx_data;
  end

  ack_follows_req: assert property (
    @(posedge clk) disable iff (!reset_n) $rose(tx_ack) |-> $past(tx_req)
  );

endmodule

// ==== src/uart_transmitter.sv ====
`timescale 1ns/1ps

module uart_transmitter import uart_pkg::*; #(
  parameter int clk_freq = 3686400
) (
  input  logic  clk,
  input  logic  reset_n,
  input  lcr_t  lcr,
  input  logic  hold_valid,
  input  byte_t hold_data,
  output logic  tx_take,
  output logic  txd
);

  tx_state_e  state;
  logic [9:0] shift;
  logic       parity_bit;
  logic       tick;
  logic       ready;
  logic       finish;

  assign tx_take    = (state == TX_IDLE) && hold_valid;
  assign parity_bit = lcr.parity_en ? ^hold_data : 1'b1;  // Even parity, else stop level.

  baud_generator #(
    .clk_freq   (clk_freq),
    .sampling   (1),
    .frame_ticks(frame_bits)
  ) i_baud_generator (
    .clk     (clk),
    .reset_n (reset_n),
    .baud_sel(lcr.baud_sel),
    .start   (tx_take),
    .tick    (tick),
    .ready   (ready),
    .finish  (finish)
  );

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= TX_IDLE;
      txd   <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          if (tx_take) state <= TX_START;
        end
        TX_START: begin
          if (ready) begin
            txd   <= 1'b0;  // Start bit.
            state <= TX_SHIFT;
          end
        end
        TX_SHIFT: begin
          if (finish) begin
            txd   <= 1'b1;
            state <= TX_IDLE;
          end else if (tick) begin
            txd <= shift[0];
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Data LSB first, then parity and stop; ones fill in behind.
  always_ff @(posedge clk) begin
    if (tx_take) begin
      shift <= {1'b1, parity_bit, hold_data};
    end else if (tick) begin
      shift <= {1'b1, shift[9:1]};
    end
  end

endmodule

// ==== src/uart_receiver.sv ====
`timescale 1ns/1ps

module uart_receiver import uart_pkg::*; #(
  parameter int clk_freq = 3686400
) (
  input  logic     clk,
  input  logic     reset_n,
  input  lcr_t     lcr,
  input  logic     rxd,
  output logic     rx_valid,
  output rx_word_t rx_word
);

  localparam int os_w = $clog2(oversample);
  localparam logic [os_w-1:0] mid_tick  = os_w'(oversample / 2 - 1);
  localparam logic [os_w-1:0] last_tick = os_w'(oversample - 1);

  rx_state_e       state;
  logic            rxd_meta;
  logic            rxd_sync;
  logic            rxd_prev;
  logic            fall;
  logic            edge_pending;
  logic            start;
  logic            sample;
  logic [os_w-1:0] os_cnt;
  logic [2:0]      bit_cnt;
  byte_t           data_sr;
  logic            parity_bit;
  logic            tick;
  logic            ready;
  logic            finish;

  assign fall   = rxd_prev && !rxd_sync;
  assign start  = (state == RX_IDLE) && (fall || edge_pending);
  assign sample = tick && (os_cnt == last_tick);

  baud_generator #(
    .clk_freq   (clk_freq),
    .sampling   (oversample),
    .frame_ticks(frame_bits * oversample)
  ) i_baud_generator (
    .clk     (clk),
    .reset_n (reset_n),
    .baud_sel(lcr.baud_sel),
    .start   (start),
    .tick    (tick),
    .ready   (ready),
    .finish  (finish)
  );

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= RX_IDLE;
      os_cnt       <= '0;
      bit_cnt      <= '0;
      edge_pending <= 1'b0;
      rx_valid     <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      // An edge seen after the stop sample starts the next frame.
      if (start) begin
        edge_pending <= 1'b0;
      end else if ((state == RX_WAIT) && fall) begin
        edge_pending <= 1'b1;
      end
      if (ready) begin
        os_cnt <= '0;
      end else if (tick) begin
        os_cnt <= os_cnt + 1'b1;
      end
      if (finish) begin
        state <= RX_IDLE;
      end else begin
        case (state)
          RX_IDLE: begin
            if (start) state <= RX_START;
          end
          RX_START: begin
            if (tick && (os_cnt == mid_tick)) begin
              os_cnt  <= '0;
              bit_cnt <= '0;
              state   <= rxd_sync ? RX_WAIT : RX_DATA;  // High here is a false start.
            end
          end
          RX_DATA: begin
            if (sample) begin
              bit_cnt <= bit_cnt + 3'd1;
              if (bit_cnt == 3'd7) state <= lcr.parity_en ? RX_PARITY : RX_STOP;
            end
          end
          RX_PARITY: begin
            if (sample) state <= RX_STOP;
          end
          RX_STOP: begin
            if (sample) begin
              rx_valid <= 1'b1;
              state    <= RX_WAIT;
            end
          end
          default: ;  // Wait for the end of the frame.
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) parity_bit <= 1'b0;
    if ((state == RX_DATA) && sample) data_sr <= {rxd_sync, data_sr[7:1]};
    if ((state == RX_PARITY) && sample) parity_bit <= rxd_sync;
    if ((state == RX_STOP) && sample) begin
      rx_word.data          <= data_sr;
      rx_word.parity_error  <= lcr.parity_en && (^data_sr ^ parity_bit);
      rx_word.framing_error <= !rxd_sync;
      rx_word.overrun       <= 1'b0;  // Set later by the read port.
    end
  end

endmodule

// ==== src/host_read_port.sv ====
`timescale 1ns/1ps

module host_read_port import uart_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     rx_valid,
  input  rx_word_t rx_word,
  output logic     rx_req,
  input  logic     rx_ack,
  output rx_word_t rx_out
);

  typedef enum logic [1:0] {
    RP_IDLE,
    RP_REQ,
    RP_DRAIN
  } rp_state_e;

  rp_state_e state;
  logic      accept;
  logic      overrun_pending;

  assign accept = (state == RP_IDLE) && rx_valid;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state           <= RP_IDLE;
      rx_req          <= 1'b0;
      overrun_pending <= 1'b0;
    end else begin
      if (accept) begin
        overrun_pending <= 1'b0;
      end else if (rx_valid) begin
        overrun_pending <= 1'b1;  // Word dropped.
      end
      case (state)
        RP_IDLE: begin
          if (rx_valid) begin
            rx_req <= 1'b1;
            state  <= RP_REQ;
          end
        end
        RP_REQ: begin
          if (rx_ack) begin
            rx_req <= 1'b0;
            state  <= RP_DRAIN;
          end
        end
        RP_DRAIN: begin
          if (!rx_ack) state <= RP_IDLE;
        end
        default: state <= RP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rx_out         <= rx_word;
      rx_out.overrun <= rx_word.overrun || overrun_pending;
    end
  end

  word_stable_during_req: assert property (
    @(posedge clk) disable iff (!reset_n) rx_req && $past(rx_req) |-> $stable(rx_out)
  );

endmodule

// ==== src/uart_core.sv ====
`timescale 1ns/1ps

module uart_core import uart_pkg::*; #(
  parameter int clk_freq = 3686400
) (
  input  logic     clk,
  input  logic     reset_n,
  input  lcr_t     lcr,
  input  logic     tx_req,
  input  byte_t    tx_data,
  output logic     tx_ack,
  output logic     txd,
  input  logic     rxd,
  output logic     rx_req,
  input  logic     rx_ack,
  output rx_word_t rx_word
);

  logic     hold_valid;
  byte_t    hold_data;
  logic     tx_take;
  logic     rx_valid;
  rx_word_t rx_frame;

  host_write_port i_host_write_port (
    .clk       (clk),
    .reset_n   (reset_n),
    .tx_req    (tx_req),
    .tx_data   (tx_data),
    .tx_ack    (tx_ack),
    .hold_valid(hold_valid),
    .hold_data (hold_data),
    .tx_take   (tx_take)
  );

  uart_transmitter #(.clk_freq(clk_freq)) i_uart_transmitter (
    .clk       (clk),
    .reset_n   (reset_n),
    .lcr       (lcr),
    .hold_valid(hold_valid),
    .hold_data (hold_data),
    .tx_take   (tx_take),
    .txd       (txd)
  );

  uart_receiver #(.clk_freq(clk_freq)) i_uart_receiver (
    .clk     (clk),
    .reset_n (reset_n),
    .lcr     (lcr),
    .rxd     (rxd),
    .rx_valid(rx_valid),
    .rx_word (rx_frame)
  );

  host_read_port i_host_read_port (
    .clk     (clk),
    .reset_n (reset_n),
    .rx_valid(rx_valid),
    .rx_word (rx_frame),
    .rx_req  (rx_req),
    .rx_ack  (rx_ack),
    .rx_out  (rx_word)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int half_period  = 10,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    reset_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

// ==== testbench/tb_uart.sv ====
`timescale 1ns/1ps

module tb_uart import uart_pkg::*; ();

  localparam int clk_freq  = 3686400;
  localparam int max_cases = 32;
  localparam int slow_bit  = clk_freq / 4800;  // Clocks per bit at the slowest rate.

  logic     clk;
  logic     reset_n;
  lcr_t     lcr;
  logic     tx_req;
  byte_t    tx_data;
  logic     tx_ack;
  logic     txd;
  logic     rxd;
  logic     rx_req;
  logic     rx_ack;
  rx_word_t rx_word;

  logic [7:0] cases [0:5*max_cases-1];  // Five fields per test case.
  integer     seed = 32'h8d3a2f07;
  int         n_cases;
  int         frames;
  int         mismatches = 0;
  int         stalls = 0;
  int         setup_errors = 0;
  int         cycles = 0;
  int         cycle_limit = 0;
  int         bit_len;     // Clocks per bit at the current rate.
  int         wait_limit;  // Longest handshake wait in the current case.
  logic       loopback;

  tb_clock_gen #(
    .half_period (10),
    .reset_cycles(2)
  ) i_tb_clock_gen (
    .clk    (clk),
    .reset_n(reset_n)
  );

  uart_core #(.clk_freq(clk_freq)) i_uart_core (
    .clk    (clk),
    .reset_n(reset_n),
    .lcr    (lcr),
    .tx_req (tx_req),
    .tx_data(tx_data),
    .tx_ack (tx_ack),
    .txd    (txd),
    .rxd    (rxd),
    .rx_req (rx_req),
    .rx_ack (rx_ack),
    .rx_word(rx_word)
  );

  always @(posedge clk) begin
    if (loopback) rxd <= txd;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int rate_clocks(input logic [2:0] sel);
    int rate;
    case (sel)
      3'd0:    rate = 4800;
      3'd1:    rate = 9600;
      3'd2:    rate = 14400;
      3'd3:    rate = 19200;
      3'd4:    rate = 38400;
      3'd5:    rate = 57600;
      3'd6:    rate = 115200;
      default: rate = 230400;
    endcase
    return clk_freq / rate;
  endfunction

  // Line levels in send order, start bit in bit 0; idle ones behind.
  function automatic logic [10:0] build_frame(input byte_t value, input logic parity_en,
                                              input logic [7:0] fault);
    logic [10:0] frame;
    logic        stop;
    stop  = (fault != 8'd2);
    frame = {2'b11, value, 1'b0};
    if (parity_en) begin
      frame[9]  = ^value ^ (fault == 8'd1);  // Even parity, flipped on a parity fault.
      frame[10] = stop;
    end else begin
      frame[9] = stop;
    end
    return frame;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      mismatches++;
      $display("FAILED at %0t ns: %s = %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic check_word(input rx_word_t actual, input byte_t data, input logic perr,
                            input logic ferr, input logic ovr);
    check_value("rx_word.data", actual.data, data);
    check_value("rx_word.parity_error", actual.parity_error, perr);
    check_value("rx_word.framing_error", actual.framing_error, ferr);
    check_value("rx_word.overrun", actual.overrun, ovr);
  endtask

  task automatic report_stall(input string what);
    stalls++;
    $display("Handshake stall at %0t ns: %s", $time, what);
  endtask

  task automatic send_byte(input byte_t value, output int waited);
    int n;
    n = 0;
    @(posedge clk);
    tx_req  <= 1'b1;
    tx_data <= value;
    @(negedge clk);
    while (!tx_ack && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    waited = n;
    if (!tx_ack) report_stall("tx_ack never rose for a pending write");
    @(posedge clk);
    tx_req <= 1'b0;
    n = 0;
    @(negedge clk);
    while (tx_ack && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (tx_ack) report_stall("tx_ack stayed high after tx_req dropped");
  endtask

  task automatic wait_rx_word(output rx_word_t word);
    int n;
    n = 0;
    @(negedge clk);
    while (!rx_req && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!rx_req) report_stall("rx_req never rose for an expected word");
    word = rx_word;
  endtask

  task automatic ack_rx_word();
    int n;
    int delay;
    n     = 0;
    delay = $unsigned($random(seed)) % 4;
    repeat (delay) @(posedge clk);
    @(posedge clk);
    rx_ack <= 1'b1;
    @(negedge clk);
    while (rx_req && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (rx_req) report_stall("rx_req stayed high after rx_ack rose");
    @(posedge clk);
    rx_ack <= 1'b0;
  endtask

  // Samples txd in the middle of each bit of the next frame.
  task automatic capture_txd(output logic [10:0] bits);
    int n;
    int k;
    n    = 0;
    bits = '1;
    @(negedge clk);
    while (txd && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (txd) begin
      report_stall("no start bit appeared on txd");
    end else begin
      repeat (bit_len / 2) @(posedge clk);
      @(negedge clk);
      bits[0] = txd;
      for (k = 1; k < 11; k++) begin
        repeat (bit_len) @(posedge clk);
        @(negedge clk);
        bits[k] = txd;
      end
    end
  endtask

  task automatic inject_frame(input logic [10:0] frame, input int n_bits);
    int k;
    for (k = 0; k < n_bits; k++) begin
      @(posedge clk);
      rxd <= frame[k];
      repeat (bit_len - 1) @(posedge clk);
    end
    @(posedge clk);
    rxd <= 1'b1;
  endtask

  task automatic run_loopback(input byte_t data, input logic par);
    logic [10:0] bits;
    rx_word_t    word;
    int          waited;
    fork
      send_byte(data, waited);
      capture_txd(bits);
    join
    check_value("txd frame", bits, build_frame(data, par, 8'd0));
    if (par) check_value("txd parity bit", bits[9], ^data);
    wait_rx_word(word);
    check_word(word, data, 1'b0, 1'b0, 1'b0);
    ack_rx_word();
  endtask

  task automatic run_injected(input byte_t data, input logic par, input logic [7:0] fault);
    logic [10:0] frame;
    rx_word_t    word;
    frame = build_frame(data, par, fault);
    @(negedge clk);
    loopback = 1'b0;
    fork
      inject_frame(frame, par ? 11 : 10);
      begin
        wait_rx_word(word);
        check_word(word, data, par && (fault == 8'd1), fault == 8'd2, 1'b0);
        ack_rx_word();
      end
    join
    @(negedge clk);
    loopback = 1'b1;
  endtask

  task automatic run_read_backpressure(input byte_t data);
    logic [10:0] bits;
    rx_word_t    word;
    int          waited;
    byte_t       second;
    byte_t       third;
    second = ~data;
    third  = data ^ 8'h5a;
    send_byte(data, waited);
    wait_rx_word(word);
    check_word(word, data, 1'b0, 1'b0, 1'b0);
    fork
      send_byte(second, waited);
      capture_txd(bits);
    join
    repeat (bit_len) @(posedge clk);  // Second word has reached the full port.
    @(negedge clk);
    check_value("rx_req", rx_req, 1'b1);
    check_value("rx_word.data", rx_word.data, data);
    ack_rx_word();
    send_byte(third, waited);
    wait_rx_word(word);
    check_word(word, third, 1'b0, 1'b0, 1'b1);
    ack_rx_word();
  endtask

  task automatic run_write_backpressure(input byte_t data);
    rx_word_t word;
    int       waited;
    int       k;
    byte_t    values [3];
    values[0] = data;
    values[1] = ~data;
    values[2] = data + 8'd1;
    fork
      begin
        send_byte(values[0], waited);
        send_byte(values[1], waited);
        send_byte(values[2], waited);
        // Third byte waits until the first frame is nearly out.
        check_value("tx_ack stall", waited >= 8 * bit_len, 1'b1);
      end
      begin
        for (k = 0; k < 3; k++) begin
          wait_rx_word(word);
          check_word(word, values[k], 1'b0, 1'b0, 1'b0);
          ack_rx_word();
        end
      end
    join
  endtask

  task automatic run_case(input int idx);
    logic [7:0] mode;
    logic [7:0] fault;
    logic [2:0] sel;
    byte_t      data;
    logic       par;
    mode       = cases[5 * idx];
    sel        = cases[5 * idx + 1][2:0];
    par        = cases[5 * idx + 2][0];
    data       = cases[5 * idx + 3];
    fault      = cases[5 * idx + 4];
    bit_len    = rate_clocks(sel);
    wait_limit = 24 * bit_len + 64;
    @(posedge clk);
    lcr <= {sel, par};
    repeat (2) @(posedge clk);  // Divisor register follows the new rate.
    case (mode)
      8'd0:    run_loopback(data, par);
      8'd1:    run_injected(data, par, fault);
      8'd2:    run_read_backpressure(data);
      default: run_write_backpressure(data);
    endcase
    repeat (2 * bit_len + 16) @(posedge clk);  // Let both frames end.
  endtask

  initial begin
    int idx;
    lcr      = '0;
    tx_req   = 1'b0;
    tx_data  = '0;
    rxd      = 1'b1;
    rx_ack   = 1'b0;
    loopback = 1'b1;
    $readmemh("testbench/uart_input.txt", cases);
    n_cases = 0;
    frames  = 0;
    while (n_cases < max_cases && !$isunknown(cases[5 * n_cases])) begin
      frames += (cases[5 * n_cases] >= 8'd2) ? 3 : 1;
      n_cases++;
    end
    // Every frame bounded by 11 bits at 4800 baud, plus gaps per case.
    cycle_limit = frames * frame_bits * slow_bit + n_cases * 4 * slow_bit + 1000;
    if (n_cases == 0) begin
      setup_errors++;
      $display("No test cases could be read from testbench/uart_input.txt");
    end
    wait (reset_n === 1'b1);
    for (idx = 0; idx < n_cases; idx++) begin
      run_case(idx);
    end
    $display("Errors: %0d mismatches, %0d handshake stalls, %0d setup", mismatches, stalls,
             setup_errors);
    if (mismatches + stalls + setup_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/uart_input.txt ====
// mode baud_sel parity_en data fault, all hex
// mode 0 loopback 1 injected 2 read back-pressure 3 write back-pressure; fault 1 parity 2 stop
0 0 0 a5 0
0 1 0 3c 0
0 2 0 01 0
0 3 0 80 0
0 4 0 ff 0
0 5 0 00 0
0 6 0 5a 0
0 7 0 c3 0
0 7 1 96 0
0 6 1 37 0
1 7 1 4e 1
1 6 0 d2 2
2 7 0 69 0
3 6 1 b7 0

// ==== files.f ====
src/uart_pkg.sv
src/baud_generator.sv
src/host_write_port.sv
src/uart_transmitter.sv
src/uart_receiver.sv
src/host_read_port.sv
src/uart_core.sv
testbench/tb_clock_gen.sv
testbench/tb_uart.sv
